// ==== include/bypass_params.svh ====
`ifndef BYPASS_PARAMS_SVH
`define BYPASS_PARAMS_SVH

// Register address width
`define BYP_REG_ADDR_W 5

// Datapath width
`define BYP_DATA_W 32

// Architectural register count, register 0 included
`define BYP_NUM_REGS 32

// Width of the LI immediate before sign extension
`define BYP_IMM_W 16

`endif

// ==== logic/bypass_pkg.sv ====
`include "bypass_params.svh"

package bypass_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_LI  = 2'd3
  } op_e;

  // One lane of an issued pair
  typedef struct packed {
    logic                       valid;
    op_e                        op;
    logic [`BYP_REG_ADDR_W-1:0] rs;
    logic [`BYP_REG_ADDR_W-1:0] rt;
    logic [`BYP_REG_ADDR_W-1:0] rd;
    logic [`BYP_IMM_W-1:0]      imm;
  } instr_t;

  // Register write carried by one lane in one stage
  typedef struct packed {
    logic                       regwrite;
    logic [`BYP_REG_ADDR_W-1:0] rd;
    logic [`BYP_DATA_W-1:0]     data;
  } wr_t;

  // One-hot operand source, bit 0 is the register file
  typedef struct packed {
    logic mem2;
    logic ex2;
    logic mem1;
    logic ex1;
    logic rf;
  } fwd_sel_t;

  localparam fwd_sel_t FWD_RF   = 5'b00001;
  localparam fwd_sel_t FWD_EX1  = 5'b00010;
  localparam fwd_sel_t FWD_MEM1 = 5'b00100;
  localparam fwd_sel_t FWD_EX2  = 5'b01000;
  localparam fwd_sel_t FWD_MEM2 = 5'b10000;

endpackage

// ==== logic/result_bus_if.sv ====
// In-flight register writes of both lanes, seen by decode
interface result_bus_if;

  // Combinational ALU results of the pair in EX
  bypass_pkg::wr_t ex1;
  bypass_pkg::wr_t ex2;

  // Contents of the MEM register
  bypass_pkg::wr_t mem1;
  bypass_pkg::wr_t mem2;

  modport producer (
    output ex1,
    output ex2,
    output mem1,
    output mem2
  );

  modport consumer (
    input ex1,
    input ex2,
    input mem1,
    input mem2
  );

endinterface

// ==== logic/forwarding_unit.sv ====
`include "bypass_params.svh"

module forwarding_unit (
  input  logic [`BYP_REG_ADDR_W-1:0] rs1,
  input  logic [`BYP_REG_ADDR_W-1:0] rt1,
  input  logic [`BYP_REG_ADDR_W-1:0] rs2,
  input  logic [`BYP_REG_ADDR_W-1:0] rt2,
  result_bus_if.consumer             bus,
  output bypass_pkg::fwd_sel_t       fwd_a1,
  output bypass_pkg::fwd_sel_t       fwd_b1,
  output bypass_pkg::fwd_sel_t       fwd_a2,
  output bypass_pkg::fwd_sel_t       fwd_b2
);

  localparam int AW = `BYP_REG_ADDR_W;

  // All vectors below are ordered youngest first: ex2, ex1, mem2, mem1
  logic [3:0][AW-1:0] dst_rd;
  logic [3:0]         live;
  logic [3:0]         hit_a1;
  logic [3:0]         hit_b1;
  logic [3:0]         hit_a2;
  logic [3:0]         hit_b2;

  function automatic logic [3:0] match(
    input logic [AW-1:0]        src,
    input logic [3:0][AW-1:0]   dst
  );
    logic [3:0] eq;
    for (int i = 0; i < 4; i++) begin
      eq[i] = (src == dst[i]);
    end
    return eq;
  endfunction

  // Youngest producer wins, register file when nothing matches
  function automatic bypass_pkg::fwd_sel_t encode(input logic [3:0] hit);
    bypass_pkg::fwd_sel_t sel;
    if (hit[3]) begin
      sel = bypass_pkg::FWD_EX2;
    end else if (hit[2]) begin
      sel = bypass_pkg::FWD_EX1;
    end else if (hit[1]) begin
      sel = bypass_pkg::FWD_MEM2;
    end else if (hit[0]) begin
      sel = bypass_pkg::FWD_MEM1;
    end else begin
      sel = bypass_pkg::FWD_RF;
    end
    return sel;
  endfunction

  assign dst_rd = {bus.ex2.rd, bus.ex1.rd, bus.mem2.rd, bus.mem1.rd};

  // Register 0 is never a source
  assign live[3] = bus.ex2.regwrite && (bus.ex2.rd != '0);
  assign live[2] = bus.ex1.regwrite && (bus.ex1.rd != '0);
  assign live[1] = bus.mem2.regwrite && (bus.mem2.rd != '0);
  assign live[0] = bus.mem1.regwrite && (bus.mem1.rd != '0);

  // Compare all four sources in parallel
  assign hit_a1 = live & match(rs1, dst_rd);
  assign hit_b1 = live & match(rt1, dst_rd);
  assign hit_a2 = live & match(rs2, dst_rd);
  assign hit_b2 = live & match(rt2, dst_rd);

  assign fwd_a1 = encode(hit_a1);
  assign fwd_b1 = encode(hit_b1);
  assign fwd_a2 = encode(hit_a2);
  assign fwd_b2 = encode(hit_b2);

endmodule

// ==== logic/register_file.sv ====
`include "bypass_params.svh"

module register_file (
  input  logic                              clk,
  input  logic                              rst,
  input  bypass_pkg::wr_t                   wb1,
  input  bypass_pkg::wr_t                   wb2,
  input  logic [3:0][`BYP_REG_ADDR_W-1:0]   raddr,
  output logic [3:0][`BYP_DATA_W-1:0]       rdata
);

  localparam int DW = `BYP_DATA_W;
  localparam int NR = `BYP_NUM_REGS;

  // Register 0 has no storage
  logic [DW-1:0] regs [1:NR-1];

  logic wr1_en;
  logic wr2_en;

  assign wr1_en = wb1.regwrite && (wb1.rd != '0);
  assign wr2_en = wb2.regwrite && (wb2.rd != '0);

  // Lane 2 is written last so it wins on a shared rd
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NR; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr1_en) regs[wb1.rd] <= wb1.data;
      if (wr2_en) regs[wb2.rd] <= wb2.data;
    end
  end

  // Write-through so WB values are visible in the same cycle
  always_comb begin
    for (int p = 0; p < 4; p++) begin
      if (raddr[p] == '0) begin
        rdata[p] = '0;
      end else if (wr2_en && (wb2.rd == raddr[p])) begin
        rdata[p] = wb2.data;
      end else if (wr1_en && (wb1.rd == raddr[p])) begin
        rdata[p] = wb1.data;
      end else begin
        rdata[p] = regs[raddr[p]];
      end
    end
  end

endmodule

// ==== logic/decode_stage.sv ====
`include "bypass_params.svh"

module decode_stage (
  input  logic                              clk,
  input  logic                              rst,
  input  bypass_pkg::instr_t                in1,
  input  bypass_pkg::instr_t                in2,
  result_bus_if.consumer                    bus,
  output logic [3:0][`BYP_REG_ADDR_W-1:0]   raddr,
  input  logic [3:0][`BYP_DATA_W-1:0]       rdata,
  output bypass_pkg::instr_t                ex1,
  output bypass_pkg::instr_t                ex2,
  output logic [`BYP_DATA_W-1:0]            ex_a1,
  output logic [`BYP_DATA_W-1:0]            ex_b1,
  output logic [`BYP_DATA_W-1:0]            ex_a2,
  output logic [`BYP_DATA_W-1:0]            ex_b2
);

  localparam int DW = `BYP_DATA_W;

  bypass_pkg::instr_t   id1;
  bypass_pkg::instr_t   id2;
  bypass_pkg::fwd_sel_t fwd_a1;
  bypass_pkg::fwd_sel_t fwd_b1;
  bypass_pkg::fwd_sel_t fwd_a2;
  bypass_pkg::fwd_sel_t fwd_b2;
  logic [DW-1:0]        opnd_a1;
  logic [DW-1:0]        opnd_b1;
  logic [DW-1:0]        opnd_a2;
  logic [DW-1:0]        opnd_b2;

  // AND-OR mux, the select is one-hot
  function automatic logic [DW-1:0] pick(
    input bypass_pkg::fwd_sel_t sel,
    input logic [DW-1:0]        rf
  );
    return ({DW{sel.rf}}   & rf)            |
           ({DW{sel.ex1}}  & bus.ex1.data)  |
           ({DW{sel.mem1}} & bus.mem1.data) |
           ({DW{sel.ex2}}  & bus.ex2.data)  |
           ({DW{sel.mem2}} & bus.mem2.data);
  endfunction

  // ID stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      id1 <= '0;
      id2 <= '0;
    end else begin
      id1 <= in1;
      id2 <= in2;
    end
  end

  assign raddr = {id2.rt, id2.rs, id1.rt, id1.rs};

  forwarding_unit u_fwd (
    .rs1    (id1.rs),
    .rt1    (id1.rt),
    .rs2    (id2.rs),
    .rt2    (id2.rt),
    .bus    (bus),
    .fwd_a1 (fwd_a1),
    .fwd_b1 (fwd_b1),
    .fwd_a2 (fwd_a2),
    .fwd_b2 (fwd_b2)
  );

  // Both lanes read state from before the pair
  assign opnd_a1 = pick(fwd_a1, rdata[0]);
  assign opnd_b1 = pick(fwd_b1, rdata[1]);
  assign opnd_a2 = pick(fwd_a2, rdata[2]);
  assign opnd_b2 = pick(fwd_b2, rdata[3]);

  // ID/EX register
  always_ff @(posedge clk) begin
    if (rst) begin
      ex1   <= '0;
      ex2   <= '0;
      ex_a1 <= '0;
      ex_b1 <= '0;
      ex_a2 <= '0;
      ex_b2 <= '0;
    end else begin
      ex1   <= id1;
      ex2   <= id2;
      ex_a1 <= opnd_a1;
      ex_b1 <= opnd_b1;
      ex_a2 <= opnd_a2;
      ex_b2 <= opnd_b2;
    end
  end

endmodule

// ==== logic/result_pipeline.sv ====
`include "bypass_params.svh"

module result_pipeline (
  input  logic                   clk,
  input  logic                   rst,
  input  bypass_pkg::instr_t     ex1,
  input  bypass_pkg::instr_t     ex2,
  input  logic [`BYP_DATA_W-1:0] ex_a1,
  input  logic [`BYP_DATA_W-1:0] ex_b1,
  input  logic [`BYP_DATA_W-1:0] ex_a2,
  input  logic [`BYP_DATA_W-1:0] ex_b2,
  result_bus_if.producer         bus,
  output bypass_pkg::wr_t        wb1,
  output bypass_pkg::wr_t        wb2
);

  localparam int DW = `BYP_DATA_W;
  localparam int IW = `BYP_IMM_W;

  bypass_pkg::wr_t ex_wr1;
  bypass_pkg::wr_t ex_wr2;
  bypass_pkg::wr_t mem_wr1;
  bypass_pkg::wr_t mem_wr2;

  function automatic logic [DW-1:0] alu(
    input bypass_pkg::op_e op,
    input logic [DW-1:0]   a,
    input logic [DW-1:0]   b,
    input logic [IW-1:0]   imm
  );
    case (op)
      bypass_pkg::OP_ADD: return a + b;
      bypass_pkg::OP_SUB: return a - b;
      bypass_pkg::OP_XOR: return a ^ b;
      default:            return {{(DW-IW){imm[IW-1]}}, imm};
    endcase
  endfunction

  // Writes to register 0 are dropped here
  assign ex_wr1 = '{regwrite: ex1.valid && (ex1.rd != '0),
                    rd:       ex1.rd,
                    data:     alu(ex1.op, ex_a1, ex_b1, ex1.imm)};
  assign ex_wr2 = '{regwrite: ex2.valid && (ex2.rd != '0),
                    rd:       ex2.rd,
                    data:     alu(ex2.op, ex_a2, ex_b2, ex2.imm)};

  assign bus.ex1  = ex_wr1;
  assign bus.ex2  = ex_wr2;
  assign bus.mem1 = mem_wr1;
  assign bus.mem2 = mem_wr2;

  // MEM then WB, no work done in MEM
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr1 <= '0;
      mem_wr2 <= '0;
      wb1     <= '0;
      wb2     <= '0;
    end else begin
      mem_wr1 <= ex_wr1;
      mem_wr2 <= ex_wr2;
      wb1     <= mem_wr1;
      wb2     <= mem_wr2;
    end
  end

endmodule

// ==== logic/dual_issue_core.sv ====
`include "bypass_params.svh"

module dual_issue_core (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid1,
  input  logic [1:0]                 in_op1,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rs1,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rt1,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rd1,
  input  logic [`BYP_IMM_W-1:0]      in_imm1,
  input  logic                       in_valid2,
  input  logic [1:0]                 in_op2,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rs2,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rt2,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rd2,
  input  logic [`BYP_IMM_W-1:0]      in_imm2,
  output logic                       wb_valid1,
  output logic [`BYP_REG_ADDR_W-1:0] wb_rd1,
  output logic [`BYP_DATA_W-1:0]     wb_data1,
  output logic                       wb_valid2,
  output logic [`BYP_REG_ADDR_W-1:0] wb_rd2,
  output logic [`BYP_DATA_W-1:0]     wb_data2
);

  bypass_pkg::instr_t                    in1;
  bypass_pkg::instr_t                    in2;
  bypass_pkg::instr_t                    ex1;
  bypass_pkg::instr_t                    ex2;
  logic [`BYP_DATA_W-1:0]                ex_a1;
  logic [`BYP_DATA_W-1:0]                ex_b1;
  logic [`BYP_DATA_W-1:0]                ex_a2;
  logic [`BYP_DATA_W-1:0]                ex_b2;
  logic [3:0][`BYP_REG_ADDR_W-1:0]       rf_raddr;
  logic [3:0][`BYP_DATA_W-1:0]           rf_rdata;
  bypass_pkg::wr_t                       wb1;
  bypass_pkg::wr_t                       wb2;

  result_bus_if bus ();

  assign in1 = '{valid: in_valid1, op: bypass_pkg::op_e'(in_op1),
                 rs: in_rs1, rt: in_rt1, rd: in_rd1, imm: in_imm1};
  assign in2 = '{valid: in_valid2, op: bypass_pkg::op_e'(in_op2),
                 rs: in_rs2, rt: in_rt2, rd: in_rd2, imm: in_imm2};

  decode_stage u_decode (
    .clk   (clk),
    .rst   (rst),
    .in1   (in1),
    .in2   (in2),
    .bus   (bus.consumer),
    .raddr (rf_raddr),
    .rdata (rf_rdata),
    .ex1   (ex1),
    .ex2   (ex2),
    .ex_a1 (ex_a1),
    .ex_b1 (ex_b1),
    .ex_a2 (ex_a2),
    .ex_b2 (ex_b2)
  );

  result_pipeline u_pipe (
    .clk   (clk),
    .rst   (rst),
    .ex1   (ex1),
    .ex2   (ex2),
    .ex_a1 (ex_a1),
    .ex_b1 (ex_b1),
    .ex_a2 (ex_a2),
    .ex_b2 (ex_b2),
    .bus   (bus.producer),
    .wb1   (wb1),
    .wb2   (wb2)
  );

  register_file u_rf (
    .clk   (clk),
    .rst   (rst),
    .wb1   (wb1),
    .wb2   (wb2),
    .raddr (rf_raddr),
    .rdata (rf_rdata)
  );

  assign wb_valid1 = wb1.regwrite;
  assign wb_rd1    = wb1.rd;
  assign wb_data1  = wb1.data;
  assign wb_valid2 = wb2.regwrite;
  assign wb_rd2    = wb2.rd;
  assign wb_data2  = wb2.data;

endmodule

// ==== tb/dual_issue_assertions.sv ====
`include "bypass_params.svh"

module dual_issue_assertions (
  input logic                       clk,
  input logic                       rst,
  input logic                       wb_valid1,
  input logic [`BYP_REG_ADDR_W-1:0] wb_rd1,
  input logic                       wb_valid2,
  input logic [`BYP_REG_ADDR_W-1:0] wb_rd2,
  input logic [4:0]                 fwd_a1,
  input logic [4:0]                 fwd_b1,
  input logic [4:0]                 fwd_a2,
  input logic [4:0]                 fwd_b2
);

  int fail_count = 0;

  property sel_onehot(logic [4:0] sel);
    @(posedge clk) disable iff (rst) $onehot(sel);
  endproperty

  // Pipeline is empty right after a reset cycle
  wb_idle_after_reset: assert property (@(posedge clk) rst |=> (!wb_valid1 && !wb_valid2))
    else begin
      fail_count++;
      $error("wb_valid high in the cycle after reset");
    end

  fwd_a1_onehot: assert property (sel_onehot(fwd_a1))
    else begin
      fail_count++;
      $error("fwd_a1 is not one-hot");
    end

  fwd_b1_onehot: assert property (sel_onehot(fwd_b1))
    else begin
      fail_count++;
      $error("fwd_b1 is not one-hot");
    end

  fwd_a2_onehot: assert property (sel_onehot(fwd_a2))
    else begin
      fail_count++;
      $error("fwd_a2 is not one-hot");
    end

  fwd_b2_onehot: assert property (sel_onehot(fwd_b2))
    else begin
      fail_count++;
      $error("fwd_b2 is not one-hot");
    end

  wb1_rd_nonzero: assert property (@(posedge clk) disable iff (rst) wb_valid1 |-> wb_rd1 != '0)
    else begin
      fail_count++;
      $error("lane 1 write to register 0 reached WB");
    end

  wb2_rd_nonzero: assert property (@(posedge clk) disable iff (rst) wb_valid2 |-> wb_rd2 != '0)
    else begin
      fail_count++;
      $error("lane 2 write to register 0 reached WB");
    end

endmodule

// ==== tb/dual_issue_checker.sv ====
`include "bypass_params.svh"

module dual_issue_checker (
  input  logic                       clk,
  input  logic                       rst,
  input  int                         test_id,
  input  logic                       in_valid1,
  input  logic [1:0]                 in_op1,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rs1,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rt1,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rd1,
  input  logic [`BYP_IMM_W-1:0]      in_imm1,
  input  logic                       in_valid2,
  input  logic [1:0]                 in_op2,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rs2,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rt2,
  input  logic [`BYP_REG_ADDR_W-1:0] in_rd2,
  input  logic [`BYP_IMM_W-1:0]      in_imm2,
  input  logic                       wb_valid1,
  input  logic [`BYP_REG_ADDR_W-1:0] wb_rd1,
  input  logic [`BYP_DATA_W-1:0]     wb_data1,
  input  logic                       wb_valid2,
  input  logic [`BYP_REG_ADDR_W-1:0] wb_rd2,
  input  logic [`BYP_DATA_W-1:0]     wb_data2,
  output int                         error_count,
  output int                         check_count
);

  localparam int AW = `BYP_REG_ADDR_W;
  localparam int DW = `BYP_DATA_W;
  localparam int IW = `BYP_IMM_W;
  localparam int NR = `BYP_NUM_REGS;
  // Input strobe cycle to WB output cycle
  localparam int LATENCY = 4;

  typedef struct packed {
    logic [2:0]    test;
    logic          v1;
    logic [AW-1:0] rd1;
    logic [DW-1:0] d1;
    logic          v2;
    logic [AW-1:0] rd2;
    logic [DW-1:0] d2;
  } expect_t;

  expect_t       pending [$];
  expect_t       exp_now;
  expect_t       exp_head;
  logic [DW-1:0] model [0:NR-1];
  logic [DW-1:0] res1;
  logic [DW-1:0] res2;

  function automatic logic [DW-1:0] ref_result(
    input logic [1:0]    op,
    input logic [DW-1:0] a,
    input logic [DW-1:0] b,
    input logic [IW-1:0] imm
  );
    case (op)
      2'd0:    return a + b;
      2'd1:    return a - b;
      2'd2:    return a ^ b;
      default: return {{(DW-IW){imm[IW-1]}}, imm};
    endcase
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "reset_state";
      3'd1:    return "dist1_forward";
      3'd2:    return "dist23_forward";
      3'd3:    return "youngest_wins";
      3'd4:    return "reg0_same_pair";
      default: return "random_stream";
    endcase
  endfunction

  task automatic compare_lane(
    input int            lane,
    input logic [2:0]    test,
    input logic          ev,
    input logic [AW-1:0] erd,
    input logic [DW-1:0] ed,
    input logic          av,
    input logic [AW-1:0] ard,
    input logic [DW-1:0] ad
  );
    check_count++;
    if (ev !== av) begin
      error_count++;
      $display("ERROR test=%s lane%0d wb_valid expected %0b actual %0b",
               test_name(test), lane, ev, av);
    end else if (ev && ((erd !== ard) || (ed !== ad))) begin
      error_count++;
      $display("ERROR test=%s lane%0d write expected r%0d=%h actual r%0d=%h",
               test_name(test), lane, erd, ed, ard, ad);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      pending.delete();
      for (int r = 0; r < NR; r++) begin
        model[r] = '0;
      end
      error_count = 0;
      check_count = 0;
    end else begin
      if (pending.size() == LATENCY) begin
        exp_head = pending.pop_front();
        compare_lane(1, exp_head.test, exp_head.v1, exp_head.rd1, exp_head.d1,
                     wb_valid1, wb_rd1, wb_data1);
        compare_lane(2, exp_head.test, exp_head.v2, exp_head.rd2, exp_head.d2,
                     wb_valid2, wb_rd2, wb_data2);
      end else if (wb_valid1 || wb_valid2) begin
        // Nothing can reach WB yet after reset
        error_count++;
        $display("ERROR test=reset_state wb_valid expected 00 actual %0b%0b",
                 wb_valid1, wb_valid2);
      end
      // Both lanes see the state from before the pair
      res1 = ref_result(in_op1, model[in_rs1], model[in_rt1], in_imm1);
      res2 = ref_result(in_op2, model[in_rs2], model[in_rt2], in_imm2);
      exp_now.test = test_id[2:0];
      exp_now.v1   = in_valid1 && (in_rd1 != '0);
      exp_now.rd1  = in_rd1;
      exp_now.d1   = res1;
      exp_now.v2   = in_valid2 && (in_rd2 != '0);
      exp_now.rd2  = in_rd2;
      exp_now.d2   = res2;
      pending.push_back(exp_now);
      if (exp_now.v1) model[in_rd1] = res1;
      // lane 2 last so it keeps a shared rd
      if (exp_now.v2) model[in_rd2] = res2;
    end
  end

endmodule

// ==== tb/tb_dual_issue_core.sv ====
`include "bypass_params.svh"

module tb_dual_issue_core;

  localparam int AW = `BYP_REG_ADDR_W;
  localparam int DW = `BYP_DATA_W;
  localparam int IW = `BYP_IMM_W;
  localparam int RESET_CYCLES   = 2;
  localparam int DIRECTED_PAIRS = 23;
  localparam int RANDOM_PAIRS   = 400;
  localparam int CYCLE_LIMIT    = RESET_CYCLES + DIRECTED_PAIRS + RANDOM_PAIRS + 20;

  localparam bypass_pkg::op_e ADD = bypass_pkg::OP_ADD;
  localparam bypass_pkg::op_e SUB = bypass_pkg::OP_SUB;
  localparam bypass_pkg::op_e XOR = bypass_pkg::OP_XOR;
  localparam bypass_pkg::op_e LI  = bypass_pkg::OP_LI;

  logic          clk;
  logic          rst;
  logic          in_valid1;
  logic [1:0]    in_op1;
  logic [AW-1:0] in_rs1;
  logic [AW-1:0] in_rt1;
  logic [AW-1:0] in_rd1;
  logic [IW-1:0] in_imm1;
  logic          in_valid2;
  logic [1:0]    in_op2;
  logic [AW-1:0] in_rs2;
  logic [AW-1:0] in_rt2;
  logic [AW-1:0] in_rd2;
  logic [IW-1:0] in_imm2;
  logic          wb_valid1;
  logic [AW-1:0] wb_rd1;
  logic [DW-1:0] wb_data1;
  logic          wb_valid2;
  logic [AW-1:0] wb_rd2;
  logic [DW-1:0] wb_data2;
  int            test_id;
  int            phase;
  int            cycle_count;
  int            error_count;
  int            check_count;
  logic [31:0]   lcg_state;

  dual_issue_core UUT (
    .clk(clk), .rst(rst),
    .in_valid1(in_valid1), .in_op1(in_op1), .in_rs1(in_rs1), .in_rt1(in_rt1),
    .in_rd1(in_rd1), .in_imm1(in_imm1),
    .in_valid2(in_valid2), .in_op2(in_op2), .in_rs2(in_rs2), .in_rt2(in_rt2),
    .in_rd2(in_rd2), .in_imm2(in_imm2),
    .wb_valid1(wb_valid1), .wb_rd1(wb_rd1), .wb_data1(wb_data1),
    .wb_valid2(wb_valid2), .wb_rd2(wb_rd2), .wb_data2(wb_data2)
  );

  dual_issue_checker u_check (
    .clk(clk), .rst(rst), .test_id(test_id),
    .in_valid1(in_valid1), .in_op1(in_op1), .in_rs1(in_rs1), .in_rt1(in_rt1),
    .in_rd1(in_rd1), .in_imm1(in_imm1),
    .in_valid2(in_valid2), .in_op2(in_op2), .in_rs2(in_rs2), .in_rt2(in_rt2),
    .in_rd2(in_rd2), .in_imm2(in_imm2),
    .wb_valid1(wb_valid1), .wb_rd1(wb_rd1), .wb_data1(wb_data1),
    .wb_valid2(wb_valid2), .wb_rd2(wb_rd2), .wb_data2(wb_data2),
    .error_count(error_count), .check_count(check_count)
  );

  bind dual_issue_core dual_issue_assertions u_assert (
    .clk(clk), .rst(rst),
    .wb_valid1(wb_valid1), .wb_rd1(wb_rd1), .wb_valid2(wb_valid2), .wb_rd2(wb_rd2),
    .fwd_a1(u_decode.fwd_a1), .fwd_b1(u_decode.fwd_b1),
    .fwd_a2(u_decode.fwd_a2), .fwd_b2(u_decode.fwd_b2)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic bypass_pkg::instr_t alu_op(
    input bypass_pkg::op_e op,
    input logic [AW-1:0]   rd,
    input logic [AW-1:0]   rs,
    input logic [AW-1:0]   rt
  );
    return '{valid: 1'b1, op: op, rs: rs, rt: rt, rd: rd, imm: '0};
  endfunction

  function automatic bypass_pkg::instr_t li(input logic [AW-1:0] rd, input logic [IW-1:0] imm);
    return '{valid: 1'b1, op: LI, rs: '0, rt: '0, rd: rd, imm: imm};
  endfunction

  // Registers 0 to 7 only so hazards are frequent
  function automatic bypass_pkg::instr_t random_instr();
    logic [31:0] r;
    logic [31:0] s;
    lcg_state = lcg_next(lcg_state);
    r = lcg_state;
    lcg_state = lcg_next(lcg_state);
    s = lcg_state;
    return '{valid: (r[31:29] != 3'd0), op: bypass_pkg::op_e'(r[28:27]),
             rs: AW'(r[26:24]), rt: AW'(r[23:21]), rd: AW'(r[20:18]), imm: s[31:16]};
  endfunction

  task automatic drive_lanes(input bypass_pkg::instr_t a, input bypass_pkg::instr_t b);
    in_valid1 = a.valid;
    in_op1    = a.op;
    in_rs1    = a.rs;
    in_rt1    = a.rt;
    in_rd1    = a.rd;
    in_imm1   = a.imm;
    in_valid2 = b.valid;
    in_op2    = b.op;
    in_rs2    = b.rs;
    in_rt2    = b.rt;
    in_rd2    = b.rd;
    in_imm2   = b.imm;
  endtask

  task automatic send_pair(input bypass_pkg::instr_t a, input bypass_pkg::instr_t b);
    @(negedge clk);
    test_id = phase;
    drive_lanes(a, b);
  endtask

  task automatic idle(input int n);
    repeat (n) send_pair('0, '0);
  endtask

  task automatic report_counts();
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             check_count, error_count, UUT.u_assert.fail_count);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      report_counts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    cycle_count = 0;
    test_id     = 0;
    phase       = 0;
    lcg_state   = 32'h8840ecbd;
    drive_lanes('0, '0);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Untouched registers read zero
    phase = 0;
    idle(2);
    send_pair(alu_op(ADD, 1, 2, 3), alu_op(ADD, 4, 5, 6));

    phase = 1;
    send_pair(li(1, 16'd5), li(2, 16'd7));
    send_pair(alu_op(ADD, 3, 1, 2), alu_op(SUB, 4, 2, 1));
    send_pair(alu_op(XOR, 5, 3, 4), alu_op(ADD, 6, 4, 3));

    // One bubble hits MEM and two bubbles hit WB write-through
    phase = 2;
    send_pair(li(1, 16'd100), li(2, 16'hfffd));
    idle(1);
    send_pair(alu_op(ADD, 3, 1, 2), alu_op(SUB, 4, 1, 2));
    idle(2);
    send_pair(alu_op(XOR, 5, 3, 4), alu_op(ADD, 6, 4, 1));

    phase = 3;
    send_pair(li(1, 16'd1), li(1, 16'd2));
    send_pair(li(1, 16'd3), li(2, 16'd9));
    send_pair(li(7, 16'd5), li(1, 16'd4));
    send_pair(alu_op(ADD, 3, 1, 0), alu_op(ADD, 4, 1, 2));
    send_pair(li(1, 16'd10), li(1, 16'd11));
    send_pair(alu_op(ADD, 5, 1, 0), alu_op(SUB, 6, 1, 7));

    phase = 4;
    send_pair(li(0, 16'h1234), li(2, 16'd50));
    send_pair(alu_op(ADD, 1, 0, 0), alu_op(XOR, 3, 0, 2));
    send_pair(li(2, 16'd77), alu_op(ADD, 4, 2, 0));
    send_pair(li(5, 16'd1), li(0, 16'hbeef));
    send_pair(alu_op(ADD, 6, 0, 5), alu_op(ADD, 7, 0, 0));

    phase = 5;
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      send_pair(random_instr(), random_instr());
    end
    // Bubbles drain the last pairs out of WB
    idle(6);
    @(negedge clk);

    report_counts();
    if (error_count == 0 && UUT.u_assert.fail_count == 0 && check_count > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
logic/bypass_pkg.sv
logic/result_bus_if.sv
logic/forwarding_unit.sv
logic/register_file.sv
logic/decode_stage.sv
logic/result_pipeline.sv
logic/dual_issue_core.sv
tb/dual_issue_assertions.sv
tb/dual_issue_checker.sv
tb/tb_dual_issue_core.sv

// ==== Bender.yml ====
package:
  name: dual_issue_bypass

sources:
  - include_dirs:
      - include
    files:
      - logic/bypass_pkg.sv
      - logic/result_bus_if.sv
      - logic/forwarding_unit.sv
      - logic/register_file.sv
      - logic/decode_stage.sv
      - logic/result_pipeline.sv
      - logic/dual_issue_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/dual_issue_assertions.sv
      - tb/dual_issue_checker.sv
      - tb/tb_dual_issue_core.sv
